//--- common/cpu900_defines.svh
`ifndef CPU900_DEFINES_SVH
`define CPU900_DEFINES_SVH

// program memory address width
`define CPU_ADDR_W 16

// XWA XBC XDE XHL XIX XIY XIZ XSP
`define CPU_NREGS 8

`endif

//--- common/cpu900_pkg.sv
package cpu900_pkg;

    typedef logic [7:0] opcode_t;   // one opcode byte
    typedef logic [7:0] reg_code_t; // full register code, E0..FF hit the bank

    typedef logic [1:0] op_size_t;

    localparam op_size_t SZ_BYTE = 2'd0;
    localparam op_size_t SZ_WORD = 2'd1;
    localparam op_size_t SZ_LONG = 2'd2;

    typedef enum logic [5:0] {
        ALU_NOP  = 6'd0,
        ALU_MOVE = 6'd1
    } alu_op_e;

    // move command, control to execution
    typedef struct packed {
        alu_op_e   op;
        logic [31:0] imm;
        logic      smux;  // 1: immediate, 0: source register
        logic [2:0] we;   // one-hot long/word/byte
        reg_code_t src;
        reg_code_t dst;
    } alu_cmd_t;

    // register write report
    typedef struct packed {
        logic      en;
        logic [2:0] idx;
        logic [31:0] value; // whole register after the write
    } reg_wr_t;

endpackage

//--- design/cpu900_fetch.sv
`timescale 1ns/1ps
`include "cpu900_defines.svh"

module cpu900_fetch (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    output logic [`CPU_ADDR_W-1:0] prog_addr,
    input  logic [7:0]             prog_data,
    input  logic [1:0]             fetched,
    output logic [31:0]            op,
    output logic                   op_ok
);

    logic [47:0]            q;        // six bytes, oldest in 7:0
    logic [47:0]            nx_q;
    logic [2:0]             cnt;      // valid bytes in q
    logic [2:0]             nx_cnt;
    logic [2:0]             rem;      // bytes left after dropping
    logic                   room;
    logic [`CPU_ADDR_W-1:0] rd_addr;

    assign prog_addr = rd_addr;
    assign op        = q[31:0];
    assign op_ok     = cnt >= 3'd4;

    // drop and append in the same cycle
    always_comb begin
        rem    = cnt - {1'b0, fetched};
        room   = rem < 3'd6;
        nx_q   = q >> {fetched, 3'b000};
        nx_cnt = rem;
        if (room) begin
            nx_q[{rem, 3'b000} +: 8] = prog_data; // lands right after the last valid byte
            nx_cnt = rem + 3'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt     <= 3'd0;
            rd_addr <= '0;
        end else if (cen) begin
            cnt <= nx_cnt;
            if (room) begin
                rd_addr <= rd_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            q <= nx_q;
        end
    end

endmodule

//--- ctrl/cpu900_ctrl.sv
`timescale 1ns/1ps

module cpu900_ctrl import cpu900_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic [31:0] op,
    input  logic        op_ok,
    output logic [1:0]  fetched,
    output alu_cmd_t    cmd,
    output logic        illegal
);

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        FILL,
        HALT
    } phase_e;

    phase_e   phase;
    phase_e   nx_phase;
    alu_cmd_t nx_cmd;
    op_size_t zz;        // operand size of the current instruction
    op_size_t nx_zz;
    logic     nx_illegal;
    logic     settle;    // one idle cycle after consuming bytes
    opcode_t  op0;

    assign op0 = op[7:0];

    function automatic logic [2:0] expand_zz(input op_size_t sz);
        case (sz)
            SZ_BYTE: expand_zz = 3'b001;
            SZ_WORD: expand_zz = 3'b010;
            SZ_LONG: expand_zz = 3'b100;
            default: expand_zz = 3'b000;
        endcase
    endfunction

    // short three-bit register to full code
    function automatic reg_code_t expand_reg(input logic [2:0] r, input op_size_t sz);
        if (sz == SZ_BYTE) begin
            expand_reg = {4'he, r[2:1], 1'b0, ~r[0]}; // W at E1, A at E0
        end else begin
            expand_reg = {3'b111, r[2], r[1:0], 2'b00};
        end
    endfunction

    always_comb begin
        fetched    = 2'd0;
        nx_phase   = phase;
        nx_cmd     = cmd;
        nx_cmd.we  = 3'b000; // write strobe lasts one enabled cycle
        nx_zz      = zz;
        nx_illegal = illegal;
        if (op_ok && !settle) begin
            case (phase)
                FETCH: begin
                    nx_cmd.op   = ALU_NOP;
                    nx_cmd.smux = 1'b0;
                    casez (op0)
                        8'h00: fetched = 2'd1; // NOP
                        8'b0010_0???, 8'b0011_0???, 8'b0100_0???: begin // LD R,#
                            nx_zz       = {op0[6], op0[4]};
                            nx_cmd.dst  = expand_reg(op0[2:0], nx_zz);
                            nx_cmd.imm  = {24'd0, op[15:8]};
                            nx_cmd.op   = ALU_MOVE;
                            nx_cmd.smux = 1'b1;
                            fetched     = 2'd2;
                            if (nx_zz == SZ_BYTE) begin
                                nx_cmd.we = expand_zz(nx_zz);
                            end else begin
                                nx_phase = FILL;
                            end
                        end
                        8'b11??_0111, 8'b11??_1???: begin // register prefixes
                            if (op0[5:4] == 2'd3) begin
                                nx_illegal = 1'b1;
                                nx_phase   = HALT;
                            end else begin
                                nx_zz    = op0[5:4];
                                nx_phase = EXEC;
                                if (op0[3]) begin
                                    nx_cmd.dst = expand_reg(op0[2:0], op0[5:4]);
                                    fetched    = 2'd1;
                                end else begin
                                    nx_cmd.dst = op[15:8]; // extended code in byte 2
                                    fetched    = 2'd2;
                                end
                            end
                        end
                        default: begin
                            nx_illegal = 1'b1;
                            nx_phase   = HALT;
                        end
                    endcase
                end
                EXEC: begin // second byte after a prefix
                    nx_phase    = FETCH;
                    nx_cmd.op   = ALU_MOVE;
                    nx_cmd.smux = 1'b0;
                    casez (op0)
                        8'b1000_1???: begin // LD R,r
                            nx_cmd.src = cmd.dst;
                            nx_cmd.dst = expand_reg(op0[2:0], zz);
                            nx_cmd.we  = expand_zz(zz);
                            fetched    = 2'd1;
                        end
                        8'b1001_1???: begin // LD r,R
                            nx_cmd.src = expand_reg(op0[2:0], zz);
                            nx_cmd.we  = expand_zz(zz);
                            fetched    = 2'd1;
                        end
                        8'b1010_1???: begin // LD r,#3
                            nx_cmd.imm  = {29'd0, op0[2:0]};
                            nx_cmd.smux = 1'b1;
                            nx_cmd.we   = expand_zz(zz);
                            fetched     = 2'd1;
                        end
                        8'b0000_0011: begin // LD r,#
                            nx_cmd.imm  = {24'd0, op[15:8]};
                            nx_cmd.smux = 1'b1;
                            fetched     = 2'd2;
                            if (zz == SZ_BYTE) begin
                                nx_cmd.we = expand_zz(zz);
                            end else begin
                                nx_phase = FILL;
                            end
                        end
                        default: begin
                            nx_illegal = 1'b1;
                            nx_phase   = HALT;
                        end
                    endcase
                end
                FILL: begin // rest of a word or long immediate
                    nx_phase  = FETCH;
                    nx_cmd.we = expand_zz(zz);
                    if (zz == SZ_WORD) begin
                        nx_cmd.imm[31:16] = 16'd0;
                        nx_cmd.imm[15:8]  = op[7:0];
                        fetched           = 2'd1;
                    end else begin
                        nx_cmd.imm[31:8] = op[23:0];
                        fetched          = 2'd3;
                    end
                end
                default: ; // halted
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase   <= FETCH;
            cmd     <= '0;
            zz      <= SZ_BYTE;
            illegal <= 1'b0;
            settle  <= 1'b0;
        end else if (cen) begin
            phase   <= nx_phase;
            cmd     <= nx_cmd;
            zz      <= nx_zz;
            illegal <= nx_illegal;
            settle  <= fetched != 2'd0;
        end
    end

endmodule

//--- design/cpu900_exec.sv
`timescale 1ns/1ps
`include "cpu900_defines.svh"

module cpu900_exec import cpu900_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     cen,
    input  alu_cmd_t cmd,
    output reg_wr_t  wb
);

    logic [31:0] regs [`CPU_NREGS];
    logic [2:0]  src_idx;
    logic [2:0]  dst_idx;
    logic [31:0] src_val;
    logic [31:0] operand;
    logic [31:0] nx_val;  // destination after the lane merge
    logic        dst_ok;
    logic        do_wr;
    logic        wb_en;
    logic [2:0]  wb_idx;
    logic [31:0] wb_value;

    assign src_idx = {cmd.src[4], cmd.src[3:2]};
    assign dst_idx = {cmd.dst[4], cmd.dst[3:2]};
    assign dst_ok  = cmd.dst[7:5] == 3'b111; // E0..FF only

    assign do_wr = cen && dst_ok && (cmd.op == ALU_MOVE) && (cmd.we != 3'b000);

    // source lane moved down to bit 0
    assign src_val = regs[src_idx] >> {cmd.src[1:0], 3'b000};
    assign operand = cmd.smux ? cmd.imm : src_val;

    always_comb begin
        nx_val = regs[dst_idx];
        if (cmd.we[2]) begin
            nx_val = operand;
        end else if (cmd.we[1]) begin
            nx_val[{cmd.dst[1], 4'b0000} +: 16] = operand[15:0]; // halfword dst[1]
        end else if (cmd.we[0]) begin
            nx_val[{cmd.dst[1:0], 3'b000} +: 8] = operand[7:0];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= 32'd0;
            end
            wb_en <= 1'b0;
        end else begin
            wb_en <= do_wr; // low again on the next edge, also when cen drops
            if (do_wr) begin
                regs[dst_idx] <= nx_val;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            wb_idx   <= dst_idx;
            wb_value <= nx_val;
        end
    end

    assign wb = '{en: wb_en, idx: wb_idx, value: wb_value};

endmodule

//--- design/cpu900_top.sv
`timescale 1ns/1ps
`include "cpu900_defines.svh"

module cpu900_top import cpu900_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen,
    output logic [`CPU_ADDR_W-1:0] prog_addr,
    input  logic [7:0]             prog_data,
    output reg_wr_t                wb,
    output logic                   illegal
);

    logic [31:0] op;       // opcode window
    logic        op_ok;
    logic [1:0]  fetched;  // bytes consumed this cycle
    alu_cmd_t    cmd;

    cpu900_fetch u_fetch (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .fetched   (fetched),
        .op        (op),
        .op_ok     (op_ok)
    );

    cpu900_ctrl u_ctrl (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .op      (op),
        .op_ok   (op_ok),
        .fetched (fetched),
        .cmd     (cmd),
        .illegal (illegal)
    );

    cpu900_exec u_exec (
        .clk (clk),
        .rst (rst),
        .cen (cen),
        .cmd (cmd),
        .wb  (wb)
    );

endmodule

//--- dv/cpu900_clkgen.sv
`timescale 1ns/1ps

module cpu900_clkgen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0; // released just after the edge
    end

endmodule

//--- dv/cpu900_chk.sv
`timescale 1ns/1ps

module cpu900_chk import cpu900_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       cen,
    input logic [1:0] fetched,
    input logic [2:0] q_cnt,
    input alu_cmd_t   cmd,
    input reg_wr_t    wb,
    input logic       illegal
);

    // consumed bytes against the real queue fill
    a_fetched_in_queue: assert property (@(posedge clk) disable iff (rst)
        {1'b0, fetched} <= q_cnt)
        else $error("control consumed more bytes than the queue holds");

    a_wb_after_enabled: assert property (@(posedge clk) disable iff (rst)
        wb.en |-> $past(cen))
        else $error("register write report after a cycle with cen low");

    a_wb_follows_we: assert property (@(posedge clk) disable iff (rst)
        wb.en == $past(cen && cmd.we != 3'b000))
        else $error("register write report not one enabled cycle after the write strobe");

    a_illegal_sticky: assert property (@(posedge clk) disable iff (rst)
        illegal |=> illegal)
        else $error("illegal flag fell without reset");

endmodule

bind cpu900_top cpu900_chk u_chk (
    .clk     (clk),
    .rst     (rst),
    .cen     (cen),
    .fetched (fetched),
    .q_cnt   (u_fetch.cnt),
    .cmd     (cmd),
    .wb      (wb),
    .illegal (illegal)
);

//--- dv/cpu900_tb.sv
`timescale 1ns/1ps
`include "cpu900_defines.svh"

module cpu900_tb import cpu900_pkg::*; ();

    localparam int NUM_INSTR = 48;
    localparam int TIMEOUT   = 20000;

    logic                   clk;
    logic                   rst;
    logic                   cen;
    logic [`CPU_ADDR_W-1:0] prog_addr;
    logic [7:0]             prog_data;
    reg_wr_t                wb;
    logic                   illegal;

    logic [7:0]             prog_mem [2**`CPU_ADDR_W];
    logic [31:0]            model [`CPU_NREGS];
    logic [`CPU_ADDR_W-1:0] pc;
    logic [2:0]             exp_idx [$];  // expected write stream
    logic [31:0]            exp_val [$];
    string                  exp_name [$];
    int                     err_count;
    int                     checked;
    logic                   halted;

    cpu900_clkgen clkgen (.clk(clk), .rst(rst));

    cpu900_top UUT (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .wb        (wb),
        .illegal   (illegal)
    );

    assign prog_data = prog_mem[prog_addr]; // combinational program memory

    // byte registers sit in lanes 0 and 1 of regs 0..3, W above A
    function automatic logic [7:0] short_code(input logic [2:0] r, input op_size_t sz);
        if (sz == SZ_BYTE) begin
            return 8'he0 + {3'b000, r[2:1], 2'b00} + {7'd0, ~r[0]};
        end
        return 8'he0 + {3'b000, r, 2'b00};
    endfunction

    function automatic logic [31:0] read_lane(input logic [7:0] code);
        return model[{code[4], code[3:2]}] >> {code[1:0], 3'b000};
    endfunction

    task automatic emit_byte(input logic [7:0] b);
        prog_mem[pc] = b;
        pc = pc + 1'b1;
    endtask

    task automatic emit_imm(input logic [31:0] v, input op_size_t sz);
        int nb;
        nb = (sz == SZ_BYTE) ? 1 : (sz == SZ_WORD) ? 2 : 4;
        for (int i = 0; i < nb; i++) begin
            emit_byte(v[8*i +: 8]); // little endian
        end
    endtask

    task automatic expect_move(input logic [7:0] dst, input logic [31:0] v, input op_size_t sz,
                               input string name);
        logic [2:0]  idx;
        logic [31:0] r;
        idx = {dst[4], dst[3:2]};
        r   = model[idx];
        case (sz)
            SZ_BYTE: r[{dst[1:0], 3'b000} +: 8] = v[7:0];
            SZ_WORD: r[{dst[1], 4'b0000} +: 16] = v[15:0];
            default: r = v;
        endcase
        model[idx] = r;
        exp_idx.push_back(idx);
        exp_val.push_back(r);
        exp_name.push_back(name);
    endtask

    task automatic build_program();
        int          kind;
        op_size_t    sz;
        logic [2:0]  r;
        logic [2:0]  s;
        logic [7:0]  pre;  // register named by the prefix
        logic [31:0] imm;
        pc = '0;
        for (int n = 0; n < NUM_INSTR; n++) begin
            kind = $urandom_range(0, 5);
            sz   = op_size_t'($urandom_range(0, 2));
            r    = 3'($urandom);
            s    = 3'($urandom);
            imm  = $urandom;
            pre  = {3'b111, 5'($urandom)};
            case (sz)
                SZ_BYTE: imm = imm & 32'h0000_00ff;
                SZ_WORD: begin
                    imm    = imm & 32'h0000_ffff;
                    pre[0] = 1'b0; // halfword aligned
                end
                default: pre[1:0] = 2'b00;
            endcase
            case (kind)
                0: emit_byte(8'h00);
                1: begin
                    emit_byte(((sz == SZ_LONG) ? 8'h40 : (sz == SZ_WORD) ? 8'h30 : 8'h20)
                              | {5'd0, r});
                    emit_imm(imm, sz);
                    expect_move(short_code(r, sz), imm, sz, $sformatf("ld_R_imm #%0d", n));
                end
                default: begin
                    if ($urandom_range(0, 1) == 0) begin
                        pre = short_code(r, sz);
                        emit_byte({2'b11, sz, 1'b1, r});
                    end else begin
                        emit_byte({2'b11, sz, 4'b0111}); // extended code follows
                        emit_byte(pre);
                    end
                    case (kind)
                        2: begin
                            emit_byte({5'b10001, s});
                            expect_move(short_code(s, sz), read_lane(pre), sz,
                                        $sformatf("ld_R_r #%0d", n));
                        end
                        3: begin
                            emit_byte({5'b10011, s});
                            expect_move(pre, read_lane(short_code(s, sz)), sz,
                                        $sformatf("ld_r_R #%0d", n));
                        end
                        4: begin
                            emit_byte({5'b10101, s});
                            expect_move(pre, {29'd0, s}, sz, $sformatf("ld_R_3 #%0d", n));
                        end
                        default: begin
                            emit_byte(8'h03);
                            emit_imm(imm, sz);
                            expect_move(pre, imm, sz, $sformatf("ld_r_imm #%0d", n));
                        end
                    endcase
                end
            endcase
        end
        repeat (4) emit_byte(8'h00);
        emit_byte(8'h80); // illegal first byte halts decoding
    endtask

    task automatic drive_cen();
        forever begin
            @(posedge clk);
            #1;
            cen = ($urandom_range(0, 3) != 0);
        end
    endtask

    // reports change on the rising edge, so look mid cycle
    task automatic watch_writes();
        forever begin
            @(negedge clk);
            if (wb.en) begin
                assert (!halted) else begin
                    err_count++;
                    $display("register %0d written after the illegal halt", wb.idx);
                end
                assert (exp_idx.size() != 0) else begin
                    err_count++;
                    $display("unexpected write to register %0d, no write was due", wb.idx);
                end
                if (exp_idx.size() != 0) begin
                    checked++;
                    assert (wb.idx == exp_idx[0] && wb.value == exp_val[0]) else begin
                        err_count++;
                        $display("mismatch %s: expected reg %0d = %08h, actual reg %0d = %08h",
                                 exp_name[0], exp_idx[0], exp_val[0], wb.idx, wb.value);
                    end
                    exp_idx.delete(0);
                    exp_val.delete(0);
                    exp_name.delete(0);
                end
            end
            if (illegal) begin
                halted = 1'b1;
            end
        end
    endtask

    initial begin
        int cycles;
        cen       = 1'b0;
        err_count = 0;
        checked   = 0;
        halted    = 1'b0;
        void'($urandom(32'h89ec));
        for (int i = 0; i < `CPU_NREGS; i++) begin
            model[i] = 32'd0;
        end
        for (int a = 0; a < (1 << `CPU_ADDR_W); a++) begin
            prog_mem[a[`CPU_ADDR_W-1:0]] = a[15:8] ^ a[7:0] ^ 8'ha5;
        end
        build_program();
        cycles = 0;
        while (rst && cycles < 100) begin
            @(posedge clk);
            cycles++;
        end
        fork
            drive_cen();
            watch_writes();
        join_none
        cycles = 0;
        while (exp_idx.size() != 0 && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        assert (exp_idx.size() == 0) else begin
            err_count++;
            $display("timeout with %0d expected register writes missing", exp_idx.size());
        end
        cycles = 0;
        while (!illegal && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        assert (illegal) else begin
            err_count++;
            $display("timeout waiting for the illegal flag");
        end
        for (int i = 0; i < 32; i++) begin
            @(posedge clk); // quiet window after the halt
        end
        $display("writes checked %0d, errors %0d", checked, err_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- cpu900.f
+incdir+common
common/cpu900_pkg.sv
design/cpu900_fetch.sv
ctrl/cpu900_ctrl.sv
design/cpu900_exec.sv
design/cpu900_top.sv
dv/cpu900_clkgen.sv
dv/cpu900_chk.sv
dv/cpu900_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run with Verilator, then search the log for the fail message
rm -f sim.log
verilator --binary --timing --assert --top-module cpu900_tb -f cpu900.f -o cpu900_sim \
    && ./obj_dir/cpu900_sim > sim.log 2>&1 \
    || echo "TB FAILED" >> sim.log
cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0
